// ==== include/mcr_defs.svh ====
/*
 * MCR3 I/O wrapper constants
 * Download indices, ROM region bases, widths and timing defaults
 */
`ifndef MCR_DEFS_SVH
`define MCR_DEFS_SVH

// ==================================================
// Download stream indices
// ==================================================
`define MCR_IDX_ROM     8'd0
`define MCR_IDX_MOD     8'd1
`define MCR_IDX_DIP     8'd254

// ==================================================
// ROM image layout
// ==================================================
`define MCR_SND_BASE    25'h0_E000
`define MCR_SP_BASE     25'h1_2000
`define MCR_BG_BASE     25'h3_2000

// Address widths of the download side and the ROM write side
`define MCR_DL_AW       25
`define MCR_ROM_AW      24

// Number of DIP bytes in the bank
`define MCR_DIP_N       8

// Cycles from the end of reset to the second reset pulse
`define MCR_RESET_HOLD  16'hFFFF

// Knob movement per frame while a rotate button is held
`define MCR_SPIN_STEP   8'd4

// Idle value of an active low input byte
`define MCR_CAB_IDLE    8'hFF

`endif

// ==== rtl/mcr_pkg.sv ====
/*
 * MCR3 I/O wrapper types
 * Download beats, game selection, controls and ROM writes
 */
`include "mcr_defs.svh"

package mcr_pkg;

	// One byte of the host download stream
	typedef struct packed {
		logic                   wr;
		logic [7:0]             idx;
		logic [`MCR_DL_AW-1:0]  addr;
		logic [7:0]             data;
	} dl_beat_t;

	typedef enum logic [1:0] {
		game_tapper  = 2'd0,
		game_timber  = 2'd1,
		game_dotron  = 2'd2,
		game_journey = 2'd3
	} game_t;

	// Player controls, right sits in bit 0
	typedef struct packed {
		logic [2:0] spare;
		logic       coin;
		logic       start2;
		logic       start1;
		logic       rot_ccw;
		logic       rot_cw;
		logic       fire_d;
		logic       fire_c;
		logic       fire_b;
		logic       fire_a;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// Spinner report, toggle flips on every new delta
	typedef struct packed {
		logic              toggle;
		logic signed [7:0] delta;
	} spin_t;

	typedef enum logic [1:0] {
		rgn_main   = 2'd0,
		rgn_sound  = 2'd1,
		rgn_sprite = 2'd2,
		rgn_bg     = 2'd3
	} region_t;

	typedef struct packed {
		logic                   valid;
		region_t                region;
		logic [`MCR_ROM_AW-1:0] addr;
		logic [3:0]             be;
		logic [7:0]             data;
		logic                   spare;
	} rom_wr_t;

	// Cabinet input bytes, all active low
	typedef struct packed {
		logic [7:0] in4;
		logic [7:0] in3;
		logic [7:0] in2;
		logic [7:0] in1;
		logic [7:0] in0;
	} cab_in_t;

	typedef logic [`MCR_DIP_N-1:0][7:0] dips_t;

endpackage

// ==== rtl/rom_loader.sv ====
/*
 * ROM download router
 * Splits index 0 beats into main, sound, sprite and background writes
 */
`timescale 1ns/1ps
`include "mcr_defs.svh"

module rom_loader (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  mcr_pkg::dl_beat_t dl,
	input  logic              dl_active,
	output mcr_pkg::rom_wr_t  rom_wr,
	output logic              rom_download,
	output logic              rom_loaded
);
	import mcr_pkg::*;

	localparam int ROM_AW = `MCR_ROM_AW;

	logic [`MCR_DL_AW-1:0] snd_off;
	logic [`MCR_DL_AW-1:0] sp_off;
	logic [`MCR_DL_AW-1:0] bg_off;
	logic                  rom_beat;
	logic                  rom_download_d;
	rom_wr_t               wr_next;

	assign rom_beat = dl.wr && dl_active && (dl.idx == `MCR_IDX_ROM);
	assign snd_off  = dl.addr - `MCR_SND_BASE;
	assign sp_off   = dl.addr - `MCR_SP_BASE;
	assign bg_off   = dl.addr - `MCR_BG_BASE;

	// ==================================================
	// Region decode and address remap
	// ==================================================
	always_comb begin
		wr_next       = '0;
		wr_next.valid = rom_beat;
		wr_next.data  = dl.data;
		if (dl.addr < `MCR_SND_BASE) begin
			wr_next.region = rgn_main;
			wr_next.addr   = dl.addr[ROM_AW-1:0];
			wr_next.be     = 4'b0001;
		end else if (dl.addr < `MCR_SP_BASE) begin
			// Sound ROM is stored as 16-bit words
			wr_next.region = rgn_sound;
			wr_next.addr   = snd_off[ROM_AW:1];
			wr_next.be     = dl.addr[0] ? 4'b0010 : 4'b0001;
		end else if (dl.addr < `MCR_BG_BASE) begin
			// Four sprite ROMs merge into one 32-bit word
			wr_next.region = rgn_sprite;
			wr_next.addr   = ROM_AW'({sp_off[18:17], sp_off[14:0], sp_off[16]});
			wr_next.be     = sp_off[15] ? 4'b1100 : 4'b0011;
		end else begin
			wr_next.region = rgn_bg;
			wr_next.addr   = bg_off[ROM_AW-1:0];
			wr_next.be     = 4'b0001;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_wr <= '0;
		end else begin
			rom_wr <= wr_next;
		end
	end

	// Download level and the sticky loaded flag
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_download   <= 1'b0;
			rom_download_d <= 1'b0;
			rom_loaded     <= 1'b0;
		end else begin
			rom_download   <= dl_active && (dl.idx == `MCR_IDX_ROM);
			rom_download_d <= rom_download;
			if (rom_download_d && !rom_download) begin
				rom_loaded <= 1'b1;
			end
		end
	end

endmodule

// ==== rtl/game_config.sv ====
/*
 * Game selection and DIP bank
 * Both are written from their own download indices
 */
`timescale 1ns/1ps
`include "mcr_defs.svh"

module game_config (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  mcr_pkg::dl_beat_t dl,
	output mcr_pkg::game_t    game,
	output mcr_pkg::dips_t    dips,
	output logic              landscape
);
	import mcr_pkg::*;

	logic mod_wr;
	logic dip_wr;

	assign mod_wr = dl.wr && (dl.idx == `MCR_IDX_MOD);
	assign dip_wr = dl.wr && (dl.idx == `MCR_IDX_DIP) && (dl.addr < `MCR_DIP_N);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game <= game_tapper;
		end else if (mod_wr) begin
			// Only the low two bits pick the game
			game <= game_t'(dl.data[1:0]);
		end
	end

	// DIP bytes at addresses 0 to 7
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dips <= '0;
		end else if (dip_wr) begin
			dips[dl.addr[2:0]] <= dl.data;
		end
	end

	// Journey is the only vertical cabinet
	assign landscape = (game != game_journey);

endmodule

// ==== rtl/reset_sequencer.sv ====
/*
 * Game reset sequencer
 * Holds reset through the ROM download, then fires one delayed extra pulse
 */
`timescale 1ns/1ps
`include "mcr_defs.svh"

module reset_sequencer #(
	parameter int unsigned HOLD = `MCR_RESET_HOLD
) (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic rom_download,
	input  logic rom_loaded,
	output logic game_reset
);

	// One extra count since the pulse is taken from the registered output
	localparam int unsigned CW = $clog2(HOLD + 2);

	logic [CW-1:0] count;
	logic          second_pulse;

	assign second_pulse = (count == CW'(1));

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			count <= CW'(HOLD + 1);
		end else if (!rom_loaded) begin
			count <= CW'(HOLD + 1);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_reset <= 1'b1;
		end else begin
			game_reset <= rom_download || !rom_loaded || second_pulse;
		end
	end

endmodule

// ==== rtl/spinner_counter.sv ====
/*
 * Discs of Tron aim knob position
 * Integrates deltas of the last active spinner plus rotate button steps
 */
`timescale 1ns/1ps
`include "mcr_defs.svh"

module spinner_counter (
	input  logic           clk_sys,
	input  logic           arst_n,
	input  logic           game_reset,
	input  mcr_pkg::spin_t spin1,
	input  mcr_pkg::spin_t spin2,
	input  logic           rot_cw,
	input  logic           rot_ccw,
	input  logic           frame_strobe,
	output logic [7:0]     spin_pos
);

	logic       old_tog1;
	logic       old_tog2;
	logic       chg1;
	logic       chg2;
	logic [7:0] delta;
	logic [7:0] step;

	assign chg1 = (spin1.toggle != old_tog1);
	assign chg2 = (spin2.toggle != old_tog2);

	// Spinner 2 wins a tie
	always_comb begin
		if (chg2) begin
			delta = spin2.delta;
		end else if (chg1) begin
			delta = spin1.delta;
		end else begin
			delta = 8'd0;
		end
	end

	// Rotate buttons move the knob once per frame
	always_comb begin
		step = 8'd0;
		if (frame_strobe && rot_cw) begin
			step = step + `MCR_SPIN_STEP;
		end
		if (frame_strobe && rot_ccw) begin
			step = step - `MCR_SPIN_STEP;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			old_tog1 <= 1'b0;
			old_tog2 <= 1'b0;
			spin_pos <= 8'd0;
		end else begin
			old_tog1 <= spin1.toggle;
			old_tog2 <= spin2.toggle;
			if (game_reset) begin
				spin_pos <= 8'd0;
			end else begin
				spin_pos <= spin_pos + delta + step;
			end
		end
	end

endmodule

// ==== rtl/control_mapper.sv ====
/*
 * Cabinet input mapping
 * Packs joystick, DIP and spinner state into the per-game active low bytes
 */
`timescale 1ns/1ps
`include "mcr_defs.svh"

module control_mapper (
	input  logic             clk_sys,
	input  logic             arst_n,
	input  mcr_pkg::joy_t    joy1,
	input  mcr_pkg::joy_t    joy2,
	input  mcr_pkg::game_t   game,
	input  mcr_pkg::dips_t   dips,
	input  logic [7:0]       spin_pos,
	output mcr_pkg::cab_in_t cab_in,
	output logic             rot_cw,
	output logic             rot_ccw
);
	import mcr_pkg::*;

	joy_t    j;
	logic    coin;
	logic    service;
	cab_in_t cab_next;

	// Shared controls are the OR of both players
	assign j       = joy_t'(joy1 | joy2);
	assign rot_cw  = j.rot_cw;
	assign rot_ccw = j.rot_ccw;

	// Discs of Tron takes either start as a coin
	assign coin    = j.coin | ((game == game_dotron) & (j.start1 | j.start2));
	assign service = dips[1][0];

	// ==================================================
	// Per-game bit layouts, inverted to active low
	// ==================================================
	always_comb begin
		cab_next.in0 = ~{service, 3'b000, j.start2, j.start1, 1'b0, coin};
		cab_next.in1 = `MCR_CAB_IDLE;
		cab_next.in2 = `MCR_CAB_IDLE;
		cab_next.in3 = dips[0];
		cab_next.in4 = `MCR_CAB_IDLE;
		case (game)
			game_tapper: begin
				cab_next.in1 = ~{3'b000, j.fire_a, j.up, j.down, j.left, j.right};
				cab_next.in2 = ~{3'b000, j.fire_a, j.up, j.down, j.left, j.right};
			end
			game_timber: begin
				// Each player keeps a separate port
				cab_next.in1 = ~{2'b00, joy1.fire_a, joy1.fire_b,
					joy1.up, joy1.down, joy1.left, joy1.right};
				cab_next.in2 = ~{2'b00, joy2.fire_a, joy2.fire_b,
					joy2.up, joy2.down, joy2.left, joy2.right};
			end
			game_dotron: begin
				cab_next.in0 = ~{service, 2'b00, j.fire_a, j.start2, j.start1, 1'b0, coin};
				cab_next.in1 = ~{1'b0, spin_pos[7:1]};
				cab_next.in2 = ~{1'b0, j.fire_b, j.fire_c, j.fire_d,
					j.down, j.up, j.right, j.left};
			end
			game_journey: begin
				cab_next.in0 = ~{service, 2'b00, j.fire_a, j.start2, j.start1, 1'b0, coin};
				cab_next.in1 = ~{4'b0000, j.down, j.up, j.right, j.left};
				cab_next.in2 = ~{3'b000, j.fire_a, j.down, j.up, j.right, j.left};
			end
			default: begin
				cab_next.in1 = `MCR_CAB_IDLE;
				cab_next.in2 = `MCR_CAB_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cab_in <= '1;
		end else begin
			cab_in <= cab_next;
		end
	end

endmodule

// ==== rtl/mcr3_io_top.sv ====
/*
 * MCR3 input and loading top level
 * ROM routing, game config, reset, spinner and cabinet input mapping
 */
`timescale 1ns/1ps
`include "mcr_defs.svh"

module mcr3_io_top #(
	parameter int unsigned RESET_HOLD = `MCR_RESET_HOLD
) (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  mcr_pkg::dl_beat_t dl,
	input  logic              dl_active,
	input  mcr_pkg::joy_t     joy1,
	input  mcr_pkg::joy_t     joy2,
	input  mcr_pkg::spin_t    spin1,
	input  mcr_pkg::spin_t    spin2,
	input  logic              frame_strobe,
	output mcr_pkg::rom_wr_t  rom_wr,
	output mcr_pkg::cab_in_t  cab_in,
	output logic              game_reset,
	output logic              rom_loaded,
	output logic              landscape,
	output mcr_pkg::game_t    game
);
	import mcr_pkg::*;

	logic       rom_download;
	dips_t      dips;
	logic [7:0] spin_pos;
	logic       rot_cw;
	logic       rot_ccw;

	rom_loader u_rom_loader (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl           (dl),
		.dl_active    (dl_active),
		.rom_wr       (rom_wr),
		.rom_download (rom_download),
		.rom_loaded   (rom_loaded)
	);

	game_config u_game_config (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.dl        (dl),
		.game      (game),
		.dips      (dips),
		.landscape (landscape)
	);

	reset_sequencer #(
		.HOLD (RESET_HOLD)
	) u_reset_sequencer (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.rom_download (rom_download),
		.rom_loaded   (rom_loaded),
		.game_reset   (game_reset)
	);

	spinner_counter u_spinner_counter (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.game_reset   (game_reset),
		.spin1        (spin1),
		.spin2        (spin2),
		.rot_cw       (rot_cw),
		.rot_ccw      (rot_ccw),
		.frame_strobe (frame_strobe),
		.spin_pos     (spin_pos)
	);

	control_mapper u_control_mapper (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.joy1     (joy1),
		.joy2     (joy2),
		.game     (game),
		.dips     (dips),
		.spin_pos (spin_pos),
		.cab_in   (cab_in),
		.rot_cw   (rot_cw),
		.rot_ccw  (rot_ccw)
	);

endmodule

// ==== tb/mcr3_io_asserts.sv ====
/*
 * Download and reset assertions
 * Bound into the MCR3 I/O top level
 */
`timescale 1ns/1ps

module mcr3_io_asserts (
	input logic clk_sys,
	input logic arst_n,
	input logic wr_valid,
	input logic rom_download,
	input logic rom_loaded,
	input logic game_reset
);

	int unsigned fail_count = 0;

	// ROM writes only appear during a ROM download
	wr_in_download: assert property (@(posedge clk_sys) disable iff (!arst_n)
		wr_valid |-> rom_download)
		else begin
			fail_count = fail_count + 1;
			$error("ROM write valid while no ROM download runs");
		end

	// Loaded flag is sticky until reset
	loaded_sticky: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!$fell(rom_loaded))
		else begin
			fail_count = fail_count + 1;
			$error("rom_loaded fell without a reset");
		end

	reset_in_download: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rom_download |-> game_reset)
		else begin
			fail_count = fail_count + 1;
			$error("game_reset low during a ROM download");
		end

endmodule

bind mcr3_io_top mcr3_io_asserts u_io_asserts (
	.clk_sys      (clk_sys),
	.arst_n       (arst_n),
	.wr_valid     (rom_wr.valid),
	.rom_download (rom_download),
	.rom_loaded   (rom_loaded),
	.game_reset   (game_reset)
);

// ==== tb/mcr3_io_tb.sv ====
/*
 * Testbench for the MCR3 input and loading top level
 * Random ROM, config, joystick and spinner stimulus against a reference model
 */
`timescale 1ns/1ps
`include "mcr_defs.svh"

module mcr3_io_tb;
	import mcr_pkg::*;

	localparam int unsigned HOLD      = 40;
	localparam int unsigned ROM_BEATS = 240;
	localparam int unsigned LIMIT     = 200;

	logic        clk_sys = 1'b0;
	logic        arst_n;
	dl_beat_t    dl;
	logic        dl_active;
	joy_t        joy1;
	joy_t        joy2;
	spin_t       spin1;
	spin_t       spin2;
	logic        frame_strobe;
	rom_wr_t     rom_wr;
	cab_in_t     cab_in;
	logic        game_reset;
	logic        rom_loaded;
	logic        landscape;
	game_t       game;

	integer      seed = 32'h6a0c;
	int unsigned checks = 0;
	int unsigned errors = 0;
	int unsigned n;
	int unsigned total;
	logic [7:0]  dip_model [0:7];
	logic [7:0]  pos_model = 8'd0;
	logic [7:0]  exp_in1;
	logic [31:0] rnd;
	dl_beat_t    beat;
	rom_wr_t     exp_wr;

	always #4 clk_sys = ~clk_sys;

	mcr3_io_top #(
		.RESET_HOLD (HOLD)
	) u_mcr3_io_top (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl           (dl),
		.dl_active    (dl_active),
		.joy1         (joy1),
		.joy2         (joy2),
		.spin1        (spin1),
		.spin2        (spin2),
		.frame_strobe (frame_strobe),
		.rom_wr       (rom_wr),
		.cab_in       (cab_in),
		.game_reset   (game_reset),
		.rom_loaded   (rom_loaded),
		.landscape    (landscape),
		.game         (game)
	);

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	// One download beat, sampled on the next rising edge
	task automatic send_beat(input logic [7:0] idx, input logic [24:0] addr,
		input logic [7:0] data);
		dl        = {1'b1, idx, addr, data};
		dl_active = 1'b1;
		@(negedge clk_sys);
		dl.wr = 1'b0;
	endtask

	// ==================================================
	// Reference model
	// ==================================================
	function automatic rom_wr_t model_rom_wr(input dl_beat_t b);
		rom_wr_t     w;
		logic [24:0] off;
		w       = '0;
		w.valid = b.wr;
		w.data  = b.data;
		w.be    = 4'b0001;
		if (b.addr < `MCR_SND_BASE) begin
			w.region = rgn_main;
			w.addr   = b.addr[23:0];
		end else if (b.addr < `MCR_SP_BASE) begin
			off      = b.addr - `MCR_SND_BASE;
			w.region = rgn_sound;
			w.addr   = 24'(off >> 1);
			w.be     = b.addr[0] ? 4'b0010 : 4'b0001;
		end else if (b.addr < `MCR_BG_BASE) begin
			off      = b.addr - `MCR_SP_BASE;
			w.region = rgn_sprite;
			w.addr   = {6'd0, off[18:17], off[14:0], off[16]};
			w.be     = off[15] ? 4'b1100 : 4'b0011;
		end else begin
			w.region = rgn_bg;
			w.addr   = 24'(b.addr - `MCR_BG_BASE);
		end
		model_rom_wr = w;
	endfunction

	// Active high bits per game, inverted at the end
	function automatic cab_in_t model_cab(input joy_t p1, input joy_t p2, input game_t g,
		input logic [7:0] pos);
		joy_t       j;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		j     = joy_t'(p1 | p2);
		b0    = 8'd0;
		b1    = 8'd0;
		b2    = 8'd0;
		b0[7] = dip_model[1][0];
		b0[3] = j.start2;
		b0[2] = j.start1;
		b0[0] = j.coin | ((g == game_dotron) & (j.start1 | j.start2));
		case (g)
			game_tapper: begin
				b1 = {3'd0, j.fire_a, j.up, j.down, j.left, j.right};
				b2 = b1;
			end
			game_timber: begin
				b1 = {2'd0, p1.fire_a, p1.fire_b, p1.up, p1.down, p1.left, p1.right};
				b2 = {2'd0, p2.fire_a, p2.fire_b, p2.up, p2.down, p2.left, p2.right};
			end
			game_dotron: begin
				b0[4] = j.fire_a;
				b1    = {1'b0, pos[7:1]};
				b2    = {1'b0, j.fire_b, j.fire_c, j.fire_d, j.down, j.up, j.right, j.left};
			end
			default: begin
				b0[4] = j.fire_a;
				b1    = {4'd0, j.down, j.up, j.right, j.left};
				b2    = {3'd0, j.fire_a, j.down, j.up, j.right, j.left};
			end
		endcase
		model_cab = {8'hFF, dip_model[0], ~b2, ~b1, ~b0};
	endfunction

	// Random ROM beat in one of the four regions, sometimes idle
	task automatic make_rom_beat(output dl_beat_t b);
		logic [31:0] r;
		logic [31:0] off;
		r      = $random(seed);
		off    = $random(seed);
		b.wr   = (r[4:2] != 3'd0);
		b.idx  = `MCR_IDX_ROM;
		b.data = r[15:8];
		case (r[1:0])
			2'd0:    b.addr = 25'(off % 32'h0_E000);
			2'd1:    b.addr = `MCR_SND_BASE + 25'(off % 32'h0_4000);
			2'd2:    b.addr = `MCR_SP_BASE + 25'(off % 32'h2_0000);
			default: b.addr = `MCR_BG_BASE + 25'(off % 32'h4_0000);
		endcase
	endtask

	task automatic configure(input game_t g);
		logic [31:0] r;
		r = $random(seed);
		send_beat(`MCR_IDX_MOD, 25'd0, {r[7:2], g});
		for (int i = 0; i < 8; i++) begin
			r            = $random(seed);
			dip_model[i] = r[7:0];
			send_beat(`MCR_IDX_DIP, 25'(i), r[7:0]);
		end
		// Address 8 lies past the DIP bank
		r = $random(seed);
		send_beat(`MCR_IDX_DIP, 25'd8, r[7:0]);
		dl_active = 1'b0;
		@(negedge clk_sys);
		check_value("game", 64'(game), 64'(g));
		check_value("landscape", 64'(landscape), 64'(g != game_journey));
		check_value("cab_in.in3", 64'(cab_in.in3), 64'(dip_model[0]));
		check_value("cab_in.in0[7]", 64'(cab_in.in0[7]), 64'(!dip_model[1][0]));
	endtask

	initial begin
		arst_n       = 1'b0;
		dl           = '0;
		dl_active    = 1'b0;
		joy1         = '0;
		joy2         = '0;
		spin1        = '0;
		spin2        = '0;
		frame_strobe = 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;

		// ==================================================
		// ROM download with region routing
		// ==================================================
		for (int i = 0; i < ROM_BEATS; i++) begin
			make_rom_beat(beat);
			dl        = beat;
			dl_active = 1'b1;
			@(negedge clk_sys);
			exp_wr = model_rom_wr(beat);
			check_value("rom_wr.valid", 64'(rom_wr.valid), 64'(exp_wr.valid));
			if (exp_wr.valid) begin
				check_value("rom_wr.region", 64'(rom_wr.region), 64'(exp_wr.region));
				check_value("rom_wr.addr", 64'(rom_wr.addr), 64'(exp_wr.addr));
				check_value("rom_wr.be", 64'(rom_wr.be), 64'(exp_wr.be));
				check_value("rom_wr.data", 64'(rom_wr.data), 64'(exp_wr.data));
			end
			check_value("game_reset", 64'(game_reset), 64'd1);
		end
		dl        = '0;
		dl_active = 1'b0;

		// Loaded flag two cycles after the download level drops
		n = 0;
		while (!rom_loaded && n < LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!rom_loaded) begin
			errors++;
			$display("Timed out waiting for rom_loaded to rise after the download");
		end
		check_value("rom_loaded delay", 64'(n), 64'd2);
		check_value("game_reset", 64'(game_reset), 64'd1);
		@(negedge clk_sys);
		check_value("game_reset", 64'(game_reset), 64'd0);

		n = 0;
		while (!game_reset && n < LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!game_reset) begin
			errors++;
			$display("Timed out waiting for the second game reset pulse");
		end
		check_value("second reset delay", 64'(n), 64'(HOLD));
		@(negedge clk_sys);
		check_value("game_reset", 64'(game_reset), 64'd0);

		// ==================================================
		// Per-game control mapping
		// ==================================================
		for (int g = 0; g < 4; g++) begin
			configure(game_t'(2'(g)));
			for (int k = 0; k < 32; k++) begin
				rnd  = $random(seed);
				joy1 = joy_t'(rnd[15:0]);
				joy2 = joy_t'(rnd[31:16]);
				@(negedge clk_sys);
				check_value("cab_in", 64'(cab_in),
					64'(model_cab(joy1, joy2, game_t'(2'(g)), pos_model)));
			end
		end

		// ==================================================
		// Spinner on Discs of Tron
		// ==================================================
		configure(game_dotron);
		joy1 = '0;
		joy2 = '0;
		for (int k = 0; k < 48; k++) begin
			rnd = $random(seed);
			// Knob 1, then knob 2, then both in the same cycle
			if (k % 3 != 1) begin
				spin1.toggle = ~spin1.toggle;
				spin1.delta  = rnd[7:0];
			end
			if (k % 3 != 0) begin
				spin2.toggle = ~spin2.toggle;
				spin2.delta  = rnd[15:8];
			end
			pos_model    = pos_model + ((k % 3 == 0) ? rnd[7:0] : rnd[15:8]);
			frame_strobe = rnd[16];
			joy1.rot_cw  = rnd[17];
			joy2.rot_ccw = rnd[18];
			if (rnd[16] && rnd[17]) begin
				pos_model = pos_model + `MCR_SPIN_STEP;
			end
			if (rnd[16] && rnd[18]) begin
				pos_model = pos_model - `MCR_SPIN_STEP;
			end
			@(negedge clk_sys);
			frame_strobe = 1'b0;
			joy1         = '0;
			joy2         = '0;
			@(negedge clk_sys);
			exp_in1 = ~{1'b0, pos_model[7:1]};
			check_value("cab_in.in1", 64'(cab_in.in1), 64'(exp_in1));
		end

		total = errors + u_mcr3_io_top.u_io_asserts.fail_count;
		$display("Checks: %0d, check errors: %0d, assertion failures: %0d",
			checks, errors, total - errors);
		if (total == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
rtl/mcr_pkg.sv
rtl/rom_loader.sv
rtl/game_config.sv
rtl/reset_sequencer.sv
rtl/spinner_counter.sv
rtl/control_mapper.sv
rtl/mcr3_io_top.sv
tb/mcr3_io_asserts.sv
tb/mcr3_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MCR3 I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f files.f --top-module mcr3_io_tb -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vmcr3_io_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi
